// ==== files.f ====
+incdir+source
source/graphicsPackage.sv
source/busRegisterBank.sv
source/frameBuffer.sv
source/vgaScanout.sv
source/graphicsSystem.sv
verification/graphicsSystem_assert.sv
verification/graphicsSystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the graphics testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module graphicsSystemTb \
    -f files.f -o graphicsSystemSim

./obj_dir/graphicsSystemSim | tee simulation.log

if grep -q "tests failed" simulation.log; then
    echo "simulation reported failures"
    exit 1
fi
exit 0

// ==== source/busRegisterBank.sv ====
`timescale 1ns/1ns
`include "graphics_config.svh"

module busRegisterBank (
    input  logic                         CLK,
    input  logic                         reset,
    // Wishbone classic slave
    input  logic                         busCycle,
    input  logic                         busStrobe,
    input  logic                         busWrite,
    input  logic [`GFX_ADDR_WIDTH-1:0]   busAddress,
    input  logic [`GFX_DATA_WIDTH-1:0]   busWriteData,
    output logic [`GFX_DATA_WIDTH-1:0]   busReadData,
    output logic                         busAck,
    // Frame buffer bus port
    output graphicsPackage::pixelAddress writeAddress,
    output logic                         writeEnable,
    output logic                         writePixel,
    input  logic                         busPixel,
    // Scanout side
    output graphicsPackage::colourValue  foregroundColour,
    output graphicsPackage::colourValue  backgroundColour,
    input  logic                         frameStart,
    output logic                         frameInterrupt
);
    import graphicsPackage::*;

    // Cursor held in coordinate form
    pixelAddress cursor;
    logic access;
    logic writeAccess;
    logic statusClear;
    logic [`GFX_DATA_WIDTH-1:0] readValue;

    // New transfer only while no acknowledge is pending
    assign access      = busCycle && busStrobe && !busAck;
    assign writeAccess = access && busWrite;
    assign statusClear = writeAccess && (busAddress == `GFX_REG_STATUS) && busWriteData[0];

    // Pixel write lands in the buffer on the acknowledge edge
    assign writeAddress = cursor;
    assign writeEnable  = writeAccess && (busAddress == `GFX_REG_PIXEL);
    assign writePixel   = busWriteData[0];

    ////////////////////////////////////////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        readValue = '0;
        case (busAddress)
            `GFX_REG_X:          readValue[`GFX_X_BITS-1:0] = cursor.coordinate.x;
            `GFX_REG_Y:          readValue[`GFX_Y_BITS-1:0] = cursor.coordinate.y;
            // Buffer bit at the cursor, read in the previous cycle
            `GFX_REG_PIXEL:      readValue[0] = busPixel;
            `GFX_REG_FOREGROUND: readValue = foregroundColour;
            `GFX_REG_BACKGROUND: readValue = backgroundColour;
            `GFX_REG_STATUS:     readValue[0] = frameInterrupt;
            default:             readValue = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Acknowledge, registers and frame flag
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            busAck           <= 1'b0;
            busReadData      <= '0;
            cursor           <= '0;
            foregroundColour <= '0;
            backgroundColour <= '0;
            frameInterrupt   <= 1'b0;
        end else begin
            // Single-cycle acknowledge
            busAck <= access;
            if (access && !busWrite) begin
                busReadData <= readValue;
            end
            if (writeAccess) begin
                case (busAddress)
                    `GFX_REG_X:          cursor.coordinate.x <= busWriteData[`GFX_X_BITS-1:0];
                    `GFX_REG_Y:          cursor.coordinate.y <= busWriteData[`GFX_Y_BITS-1:0];
                    `GFX_REG_FOREGROUND: foregroundColour <= busWriteData;
                    `GFX_REG_BACKGROUND: backgroundColour <= busWriteData;
                    default:             ;
                endcase
            end
            // Sticky flag, set beats clear
            if (frameStart) begin
                frameInterrupt <= 1'b1;
            end else if (statusClear) begin
                frameInterrupt <= 1'b0;
            end
        end
    end

endmodule

// ==== source/frameBuffer.sv ====
`timescale 1ns/1ns
`include "graphics_config.svh"

module frameBuffer (
    input  logic                         CLK,
    // Bus port, read and write
    input  graphicsPackage::pixelAddress writeAddress,
    input  logic                         writeEnable,
    input  logic                         writePixel,
    output logic                         busPixel,
    // Scan port, read only
    input  graphicsPackage::pixelAddress scanAddress,
    output logic                         scanPixel
);

    // 32768 x 1 pixel store, flat index
    logic pixelMemory [0:(1 << `GFX_PIXEL_BITS) - 1];

    ////////////////////////////////////////////////////////////////////////////
    // Bus port
    ////////////////////////////////////////////////////////////////////////////

    // Read-first, so a read shows the bit before this cycle's write
    always_ff @(posedge CLK) begin
        if (writeEnable) begin
            pixelMemory[writeAddress.flat] <= writePixel;
        end
        busPixel <= pixelMemory[writeAddress.flat];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scan port
    ////////////////////////////////////////////////////////////////////////////

    // One cycle of read latency toward the scanout
    always_ff @(posedge CLK) begin
        scanPixel <= pixelMemory[scanAddress.flat];
    end

endmodule

// ==== source/graphicsPackage.sv ====
`include "graphics_config.svh"

package graphicsPackage;

    ////////////////////////////////////////////////////////////////////////////
    // Frame buffer address
    ////////////////////////////////////////////////////////////////////////////

    // Row in the upper bits, column in the lower bits
    // Same 15 bits double as the flat memory index
    typedef union packed {
        struct packed {
            logic [`GFX_Y_BITS-1:0] y;
            logic [`GFX_X_BITS-1:0] x;
        } coordinate;
        logic [`GFX_PIXEL_BITS-1:0] flat;
    } pixelAddress;

    // 8-bit pixel colour as driven on the VGA pins
    typedef logic [`GFX_DATA_WIDTH-1:0] colourValue;

endpackage

// ==== source/graphicsSystem.sv ====
`timescale 1ns/1ns
`include "graphics_config.svh"

module graphicsSystem (
    input  logic                        CLK,
    input  logic                        reset,
    // Wishbone classic bus from the processor
    input  logic                        busCycle,
    input  logic                        busStrobe,
    input  logic                        busWrite,
    input  logic [`GFX_ADDR_WIDTH-1:0]  busAddress,
    input  logic [`GFX_DATA_WIDTH-1:0]  busWriteData,
    output logic [`GFX_DATA_WIDTH-1:0]  busReadData,
    output logic                        busAck,
    output logic                        frameInterrupt,
    // VGA pins
    output logic                        VGA_HS,
    output logic                        VGA_VS,
    output graphicsPackage::colourValue VGA_COLOUR
);
    import graphicsPackage::*;

    // Buffer ports
    pixelAddress writeAddress;
    pixelAddress scanAddress;
    logic        writeEnable;
    logic        writePixel;
    logic        busPixel;
    logic        scanPixel;
    // Register bank to scanout
    colourValue  foregroundColour;
    colourValue  backgroundColour;
    logic        frameStart;

    busRegisterBank registerBank (
        .CLK(CLK), .reset(reset),
        .busCycle(busCycle), .busStrobe(busStrobe), .busWrite(busWrite),
        .busAddress(busAddress), .busWriteData(busWriteData),
        .busReadData(busReadData), .busAck(busAck),
        .writeAddress(writeAddress), .writeEnable(writeEnable),
        .writePixel(writePixel), .busPixel(busPixel),
        .foregroundColour(foregroundColour), .backgroundColour(backgroundColour),
        .frameStart(frameStart), .frameInterrupt(frameInterrupt)
    );

    frameBuffer pixelBuffer (
        .CLK(CLK),
        .writeAddress(writeAddress), .writeEnable(writeEnable),
        .writePixel(writePixel), .busPixel(busPixel),
        .scanAddress(scanAddress), .scanPixel(scanPixel)
    );

    vgaScanout scanout (
        .CLK(CLK), .reset(reset),
        .scanAddress(scanAddress), .scanPixel(scanPixel),
        .foregroundColour(foregroundColour), .backgroundColour(backgroundColour),
        .frameStart(frameStart),
        .VGA_HS(VGA_HS), .VGA_VS(VGA_VS), .VGA_COLOUR(VGA_COLOUR)
    );

endmodule

// ==== source/graphics_config.svh ====
`ifndef GRAPHICS_CONFIG_SVH
`define GRAPHICS_CONFIG_SVH

// Bus widths
`define GFX_DATA_WIDTH 8
`define GFX_ADDR_WIDTH 3

// Cursor widths, 256 x 128 buffer
`define GFX_X_BITS 8
`define GFX_Y_BITS 7
`define GFX_PIXEL_BITS (`GFX_X_BITS + `GFX_Y_BITS)
// Screen columns covered by the buffer, 2 per buffer pixel
`define GFX_SCAN_COLUMNS (2 << `GFX_X_BITS)

// Register indices, sized to the register address
`define GFX_REG_X          3'd0
`define GFX_REG_Y          3'd1
`define GFX_REG_PIXEL      3'd2
`define GFX_REG_FOREGROUND 3'd3
`define GFX_REG_BACKGROUND 3'd4
`define GFX_REG_STATUS     3'd5

// 640x480 horizontal counts in pixel clocks
`define GFX_H_ACTIVE 640
`define GFX_H_FRONT  16
`define GFX_H_SYNC   96
`define GFX_H_BACK   48
`define GFX_H_TOTAL  (`GFX_H_ACTIVE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK)

// Vertical counts in lines
`define GFX_V_ACTIVE 480
`define GFX_V_FRONT  10
`define GFX_V_SYNC   2
`define GFX_V_BACK   33
`define GFX_V_TOTAL  (`GFX_V_ACTIVE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK)

`endif

// ==== source/vgaScanout.sv ====
`timescale 1ns/1ns
`include "graphics_config.svh"

module vgaScanout (
    input  logic                         CLK,
    input  logic                         reset,
    // Frame buffer scan port
    output graphicsPackage::pixelAddress scanAddress,
    input  logic                         scanPixel,
    // Colours from the register bank
    input  graphicsPackage::colourValue  foregroundColour,
    input  graphicsPackage::colourValue  backgroundColour,
    output logic                         frameStart,
    // VGA pins
    output logic                         VGA_HS,
    output logic                         VGA_VS,
    output graphicsPackage::colourValue  VGA_COLOUR
);
    import graphicsPackage::*;

    localparam int hBits = $clog2(`GFX_H_TOTAL);
    localparam int vBits = $clog2(`GFX_V_TOTAL);

    // Counter boundaries
    localparam logic [hBits-1:0] hLast      = hBits'(`GFX_H_TOTAL - 1);
    localparam logic [hBits-1:0] hActiveEnd = hBits'(`GFX_H_ACTIVE);
    localparam logic [hBits-1:0] hBufferEnd = hBits'(`GFX_SCAN_COLUMNS);
    localparam logic [hBits-1:0] hSyncStart = hBits'(`GFX_H_ACTIVE + `GFX_H_FRONT);
    localparam logic [hBits-1:0] hSyncEnd   = hBits'(`GFX_H_ACTIVE + `GFX_H_FRONT + `GFX_H_SYNC);
    localparam logic [vBits-1:0] vLast      = vBits'(`GFX_V_TOTAL - 1);
    localparam logic [vBits-1:0] vActiveEnd = vBits'(`GFX_V_ACTIVE);
    localparam logic [vBits-1:0] vSyncStart = vBits'(`GFX_V_ACTIVE + `GFX_V_FRONT);
    localparam logic [vBits-1:0] vSyncEnd   = vBits'(`GFX_V_ACTIVE + `GFX_V_FRONT + `GFX_V_SYNC);

    logic [hBits-1:0] hCount;
    logic [vBits-1:0] vCount;
    logic activeDelayed;
    logic bufferDelayed;
    logic hSyncDelayed;
    logic vSyncDelayed;
    logic startDelayed;
    colourValue pixelColour;

    ////////////////////////////////////////////////////////////////////////////
    // Sync counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            hCount <= '0;
            vCount <= '0;
        end else if (hCount == hLast) begin
            hCount <= '0;
            vCount <= (vCount == vLast) ? '0 : vCount + 1'b1;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // Buffer pixel is 2 columns wide and 4 rows tall
    always_comb begin
        scanAddress.coordinate.x = hCount[`GFX_X_BITS:1];
        scanAddress.coordinate.y = vCount[`GFX_Y_BITS+1:2];
    end

    // Stage 1, conditions aligned with the buffer read
    always_ff @(posedge CLK) begin
        if (reset) begin
            activeDelayed <= 1'b0;
            bufferDelayed <= 1'b0;
            hSyncDelayed  <= 1'b0;
            vSyncDelayed  <= 1'b0;
            startDelayed  <= 1'b0;
        end else begin
            activeDelayed <= (hCount < hActiveEnd) && (vCount < vActiveEnd);
            bufferDelayed <= hCount < hBufferEnd;
            hSyncDelayed  <= (hCount >= hSyncStart) && (hCount < hSyncEnd);
            vSyncDelayed  <= (vCount >= vSyncStart) && (vCount < vSyncEnd);
            // First clock of the first sync line
            startDelayed  <= (vCount == vSyncStart) && (hCount == '0);
        end
    end

    // Blanking forces black, columns past the buffer show background
    always_comb begin
        if (!activeDelayed) begin
            pixelColour = '0;
        end else if (bufferDelayed && scanPixel) begin
            pixelColour = foregroundColour;
        end else begin
            pixelColour = backgroundColour;
        end
    end

    // Stage 2, output register, syncs active low
    always_ff @(posedge CLK) begin
        if (reset) begin
            VGA_HS     <= 1'b1;
            VGA_VS     <= 1'b1;
            VGA_COLOUR <= '0;
            frameStart <= 1'b0;
        end else begin
            VGA_HS     <= !hSyncDelayed;
            VGA_VS     <= !vSyncDelayed;
            VGA_COLOUR <= pixelColour;
            frameStart <= startDelayed;
        end
    end

endmodule

// ==== verification/graphicsSystemTb.sv ====
`timescale 1ns/1ns
`include "graphics_config.svh"

module graphicsSystemTb;
    import graphicsPackage::*;

    localparam int clockPeriod = 20;
    // Three frames plus the bus tests
    localparam longint watchdogCycles = 3 * 420000 + 20000;

    logic CLK = 1'b0;
    logic reset = 1'b1;
    logic busCycle = 1'b0;
    logic busStrobe = 1'b0;
    logic busWrite = 1'b0;
    logic [`GFX_ADDR_WIDTH-1:0] busAddress = '0;
    logic [`GFX_DATA_WIDTH-1:0] busWriteData = '0;
    logic [`GFX_DATA_WIDTH-1:0] busReadData;
    logic busAck;
    logic frameInterrupt;
    logic VGA_HS;
    logic VGA_VS;
    colourValue VGA_COLOUR;

    // Reference frame buffer and pattern positions
    bit refPixel [0:127][0:255];
    int patternX [3] = '{0, 128, 255};
    int patternY [3] = '{5, 60, 119};
    int sampleCols [5] = '{1, 257, 511, 600, 700};
    int errorCount = 0;
    int testCount = 0;
    int testFails = 0;
    int errorsAtStart = 0;
    longint hsFallTime;
    longint vsFallTime;
    int hsLow, hsPeriod, vsLow, vsPeriod;
    int hsFalls = 0;
    int vsFalls = 0;
    logic [7:0] fg, bg;

    graphicsSystem UUT (.*);

    bind graphicsSystem graphicsSystem_assert ruleChecks (
        .CLK(CLK), .reset(reset), .busCycle(busCycle), .busStrobe(busStrobe),
        .busAck(busAck), .frameInterrupt(frameInterrupt),
        .VGA_HS(VGA_HS), .VGA_VS(VGA_VS), .VGA_COLOUR(VGA_COLOUR)
    );

    always #(clockPeriod / 2) CLK = ~CLK;

    // Sync edge timestamps, in clock cycles
    always @(negedge VGA_HS) begin
        if (hsFalls > 0) hsPeriod = int'(($time - hsFallTime) / clockPeriod);
        hsFallTime = $time;
        hsFalls++;
    end
    always @(posedge VGA_HS) hsLow = int'(($time - hsFallTime) / clockPeriod);
    always @(negedge VGA_VS) begin
        if (vsFalls > 0) vsPeriod = int'(($time - vsFallTime) / clockPeriod);
        vsFallTime = $time;
        vsFalls++;
    end
    always @(posedge VGA_VS) vsLow = int'(($time - vsFallTime) / clockPeriod);

    task automatic checkValue(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errorCount == errorsAtStart) $display("test %s: ok", name);
        else begin
            testFails++;
            $display("test %s: %0d errors", name, errorCount - errorsAtStart);
        end
        errorsAtStart = errorCount;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone master, starts and ends 2 ns after an edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic busTransfer(input logic write, input logic [`GFX_ADDR_WIDTH-1:0] address,
                               input logic [7:0] data, output logic [7:0] result);
        int cycles;
        busCycle = 1'b1;
        busStrobe = 1'b1;
        busWrite = write;
        busAddress = address;
        busWriteData = data;
        cycles = 0;
        do begin
            @(posedge CLK);
            #1;
            cycles++;
        end while (!busAck && cycles < 16);
        checkValue("busAck latency", cycles, 1);
        result = busReadData;
        #1;
        busCycle = 1'b0;
        busStrobe = 1'b0;
        busWrite = 1'b0;
        @(posedge CLK);
        #2;
    endtask

    task automatic writeRegister(input logic [`GFX_ADDR_WIDTH-1:0] address, input logic [7:0] data);
        logic [7:0] unused;
        busTransfer(1'b1, address, data, unused);
    endtask

    task automatic readCheck(input logic [`GFX_ADDR_WIDTH-1:0] address, input int expected,
                             input string name);
        logic [7:0] value;
        busTransfer(1'b0, address, 8'h00, value);
        checkValue(name, int'(value), expected);
    endtask

    task automatic setPixel(input int x, input int y, input logic value);
        writeRegister(`GFX_REG_X, 8'(x));
        writeRegister(`GFX_REG_Y, 8'(y));
        writeRegister(`GFX_REG_PIXEL, {7'b0, value});
        refPixel[y][x] = value;
    endtask

    // Returns 2 ns after the edge that shows the first sync line
    task automatic waitVsFall();
        while (VGA_VS !== 1'b1) begin
            @(posedge CLK);
            #1;
        end
        while (VGA_VS !== 1'b0) begin
            @(posedge CLK);
            #1;
        end
        #1;
    endtask

    // Scaling rule, 2 columns by 4 rows per buffer pixel
    function automatic int expectedColour(input int col, input int row);
        if (col >= `GFX_H_ACTIVE || row >= `GFX_V_ACTIVE) return 0;
        if (col >= `GFX_SCAN_COLUMNS) return int'(bg);
        return refPixel[row / 4][col / 2] ? int'(fg) : int'(bg);
    endfunction

    initial begin
        int x, y, row, target, offset;
        logic value;
        void'($urandom(70346));
        repeat (10) @(posedge CLK);
        #2;
        reset = 1'b0;

        // Registers after reset, then read back
        checkValue("frameInterrupt", int'(frameInterrupt), 0);
        for (int a = 0; a < 8; a++) readCheck(3'(a), 0, "busReadData");
        fg = 8'($urandom);
        bg = ~fg;
        x = int'(8'($urandom));
        y = int'(7'($urandom));
        writeRegister(`GFX_REG_X, 8'(x));
        writeRegister(`GFX_REG_Y, 8'(y));
        writeRegister(`GFX_REG_FOREGROUND, fg);
        writeRegister(`GFX_REG_BACKGROUND, bg);
        readCheck(`GFX_REG_X, x, "cursor X");
        readCheck(`GFX_REG_Y, y, "cursor Y");
        readCheck(`GFX_REG_FOREGROUND, int'(fg), "foregroundColour");
        readCheck(`GFX_REG_BACKGROUND, int'(bg), "backgroundColour");
        endTest("registers");

        // Odd passes overwrite the previous pixel with its inverse
        for (int i = 0; i < 64; i++) begin
            if (i % 2 == 0) begin
                x = int'(8'($urandom));
                y = int'(7'($urandom));
                value = 1'($urandom);
            end else begin
                readCheck(`GFX_REG_PIXEL, int'(refPixel[y][x]), "pixel before write");
                value = !value;
            end
            setPixel(x, y, value);
            readCheck(`GFX_REG_PIXEL, int'(refPixel[y][x]), "pixel");
        end
        endTest("pixels");

        // Alternating pattern for the colour test, both colours on every row
        for (int i = 0; i < 9; i++) setPixel(patternX[i % 3], patternY[i / 3], 1'(i % 2));

        // First frame start
        waitVsFall();
        @(posedge CLK);
        #1;
        checkValue("frameInterrupt", int'(frameInterrupt), 1);
        #1;
        readCheck(`GFX_REG_STATUS, 1, "status");
        writeRegister(`GFX_REG_STATUS, 8'h02);
        readCheck(`GFX_REG_STATUS, 1, "status kept");
        writeRegister(`GFX_REG_STATUS, 8'h01);
        readCheck(`GFX_REG_STATUS, 0, "status cleared");
        checkValue("frameInterrupt", int'(frameInterrupt), 0);

        waitVsFall();
        checkValue("VGA_HS low", hsLow, `GFX_H_SYNC);
        checkValue("VGA_HS period", hsPeriod, `GFX_H_TOTAL);
        checkValue("VGA_VS low", vsLow, `GFX_V_SYNC * `GFX_H_TOTAL);
        checkValue("VGA_VS period", vsPeriod, `GFX_V_TOTAL * `GFX_H_TOTAL);
        endTest("sync");

        ////////////////////////////////////////////////////////////////////////
        // Colour samples, counted from the sync line that just started
        ////////////////////////////////////////////////////////////////////////
        offset = 0;
        for (int r = 0; r < 4; r++) begin
            row = (r < 3) ? 4 * patternY[r] + 2 : 500;
            for (int c = 0; c < 5; c++) begin
                target = (`GFX_V_SYNC + `GFX_V_BACK + row) * `GFX_H_TOTAL + sampleCols[c];
                repeat (target - offset) @(posedge CLK);
                #1;
                checkValue("VGA_COLOUR", int'(VGA_COLOUR), expectedColour(sampleCols[c], row));
                #1;
                offset = target;
            end
        end
        endTest("colour");

        // Flag set again at the second frame start, still pending
        checkValue("frameInterrupt", int'(frameInterrupt), 1);
        readCheck(`GFX_REG_STATUS, 1, "status");
        endTest("interrupt");

        errorCount += UUT.ruleChecks.failures;
        $display("%0d tests, %0d with errors, %0d errors in total",
                 testCount, testFails, errorCount);
        if (errorCount == 0 && testFails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdogCycles * clockPeriod);
        $display("timeout, the simulation ran past its time limit");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== verification/graphicsSystem_assert.sv ====
`timescale 1ns/1ns
`include "graphics_config.svh"

module graphicsSystem_assert (
    input logic                       CLK,
    input logic                       reset,
    input logic                       busCycle,
    input logic                       busStrobe,
    input logic                       busAck,
    input logic                       frameInterrupt,
    input logic                       VGA_HS,
    input logic                       VGA_VS,
    input logic [`GFX_DATA_WIDTH-1:0] VGA_COLOUR
);

    // Per-rule failure counts, summed for the testbench
    int ackFails = 0;
    int blankFails = 0;
    int syncFails = 0;
    int interruptFails = 0;
    int failures;
    int hsLowRun;

    assign failures = ackFails + blankFails + syncFails + interruptFails;

    // Length of the horizontal sync pulse so far
    always_ff @(posedge CLK) begin
        if (reset || VGA_HS) begin
            hsLowRun <= 0;
        end else begin
            hsLowRun <= hsLowRun + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////////////////////////////////////////

    ackSingle: assert property (@(posedge CLK) disable iff (reset)
        busAck |-> $past(busCycle && busStrobe) && !$past(busAck))
        else begin
            $error("busAck held two cycles or raised without a strobe");
            ackFails++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // VGA timing
    ////////////////////////////////////////////////////////////////////////////

    // Black whenever either sync is active
    blankDuringSync: assert property (@(posedge CLK) disable iff (reset)
        (!VGA_HS || !VGA_VS) |-> VGA_COLOUR == '0)
        else begin
            $error("VGA_COLOUR is not black during sync");
            blankFails++;
        end

    hsPulseLength: assert property (@(posedge CLK) disable iff (reset)
        $rose(VGA_HS) |-> hsLowRun == `GFX_H_SYNC)
        else begin
            $error("VGA_HS low pulse has the wrong length");
            syncFails++;
        end

    // Flag follows the vertical sync edge by one clock
    interruptAfterSync: assert property (@(posedge CLK) disable iff (reset)
        $rose(frameInterrupt) |-> $past(VGA_VS, 2) && !$past(VGA_VS))
        else begin
            $error("frameInterrupt rose without a VGA_VS falling edge");
            interruptFails++;
        end

endmodule
